// File: Bender.yml
package:
  name: utim64

sources:
  - files:
      - verilog/utim64_pkg.sv
      - verilog/utim64_async_fifo.sv
      - verilog/utim64_main_counter.sv
      - verilog/utim64_comparator.sv
      - verilog/utim64.sv
  - target: test
    files:
      - testbench/utim64_tb.sv

// File: testbench/utim64_tb.sv
`timescale 1ns/1ps

module utim64_tb;

	import utim64_pkg::*;

	localparam int wait_limit = 200;

	logic if_clock;
	logic iTIMER_CLOCK;
	logic inRESET;
	logic req_valid;
	logic req_rw;
	logic [reg_addr_width-1:0] req_addr;
	logic [data_width-1:0] req_data;
	logic busy;
	logic resp_valid;
	logic [data_width-1:0] resp_data;
	logic [3:0] irq;

	logic [31:0] rng_state;
	logic [data_width-1:0] model [0:15];
	logic [data_width-1:0] responses [$];

	utim64 #(
		.fifo_addr_width(2)
	) utim64_inst (
		.if_clock(if_clock),
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET),
		.req_valid(req_valid),
		.req_rw(req_rw),
		.req_addr(req_addr),
		.req_data(req_data),
		.busy(busy),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.irq(irq)
	);

	always #2 iTIMER_CLOCK = ~iTIMER_CLOCK;
	always #3 if_clock = ~if_clock;

	// One response per if_clock cycle with resp_valid high
	always @(negedge if_clock) begin
		if (inRESET && resp_valid) begin
			responses.push_back(resp_data);
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [31:0] cfg_word(input bit ena, input bit irqena,
		input bit mode64, input bit periodic);
		logic [31:0] w;
		w = '0;
		w[cfg_ena_bit] = ena;
		w[cfg_irqena_bit] = irqena;
		w[cfg_64mode_bit] = mode64;
		w[cfg_periodic_bit] = periodic;
		return w;
	endfunction

	// Periods 50, 70, 90 and 110 for channels 0 to 3
	function automatic int period_of(input int n);
		return 50 + 20 * n;
	endfunction

	task automatic check_value(input string test_name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %0h actual %0h", test_name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "wrong value in %s", test_name);
		end
	endtask

	task automatic report_timeout(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "%s", reason);
	endtask

	task automatic next_if_cycle();
		@(posedge if_clock);
		#1;
	endtask

	task automatic next_timer_cycle();
		@(posedge iTIMER_CLOCK);
		#1;
	endtask

	task automatic send_request(input logic rw, input logic [3:0] addr,
		input logic [31:0] data);
		int cycles;
		cycles = 0;
		while (busy) begin
			next_if_cycle();
			cycles++;
			if (cycles > wait_limit) begin
				report_timeout("Timed out waiting for busy to fall");
			end
		end
		req_valid = 1'b1;
		req_rw = rw;
		req_addr = addr;
		req_data = data;
		next_if_cycle();
		req_valid = 1'b0;
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
		send_request(1'b1, addr, data);
		if (addr != 4'd15) begin
			model[addr] = data;
		end
	endtask

	task automatic bus_read(input string test_name, input logic [3:0] addr);
		int cycles;
		send_request(1'b0, addr, '0);
		cycles = 0;
		while (responses.size() == 0) begin
			next_if_cycle();
			cycles++;
			if (cycles > wait_limit) begin
				report_timeout("Timed out waiting for a read response");
			end
		end
		check_value(test_name, model[addr], responses.pop_front());
	endtask

	task automatic wait_irq(input string test_name, input int bit_index, input int limit);
		int cycles;
		cycles = 0;
		while (!irq[bit_index]) begin
			next_timer_cycle();
			cycles++;
			if (cycles > limit) begin
				report_timeout({"Timed out waiting for an interrupt in ", test_name});
			end
		end
	endtask

	task automatic expect_quiet(input string test_name, input int cycles);
		repeat (cycles) begin
			next_timer_cycle();
			check_value(test_name, 4'h0, irq);
		end
		next_if_cycle();
	endtask

	task automatic measure_periods();
		int pulses [4];
		int second [4];
		int third [4];
		int cycles;
		int n;
		bit done;
		for (n = 0; n < 4; n++) begin
			pulses[n] = 0;
			second[n] = 0;
			third[n] = 0;
		end
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			next_timer_cycle();
			cycles++;
			if (cycles > 3000) begin
				report_timeout("Timed out waiting for periodic interrupts");
			end
			done = 1'b1;
			for (n = 0; n < 4; n++) begin
				if (irq[n]) begin
					pulses[n]++;
					if (pulses[n] == 2) second[n] = cycles;
					if (pulses[n] == 3) third[n] = cycles;
				end
				if (pulses[n] < 3) done = 1'b0;
			end
		end
		for (n = 0; n < 4; n++) begin
			check_value("periodic", period_of(n), third[n] - second[n]);
		end
		next_if_cycle();
	endtask

	task automatic test_reset_state();
		int a;
		check_value("reset busy", 1'b0, busy);
		check_value("reset resp_valid", 1'b0, resp_valid);
		check_value("reset irq", 4'h0, irq);
		for (a = 0; a < 16; a++) begin
			bus_read("reset", a);
		end
	endtask

	task automatic test_register_table();
		logic [31:0] data;
		int a;
		for (a = 0; a < 16; a++) begin
			data = next_random();
			// Keep the counter and channels disabled
			if (a == reg_main_cfg || a >= reg_cmp0_cfg) data[cfg_ena_bit] = 1'b0;
			bus_write(a, data);
		end
		for (a = 0; a < 16; a++) begin
			bus_read("register_table", a);
		end
	endtask

	task automatic test_back_pressure();
		logic [3:0] addrs [12];
		logic [31:0] r;
		int n;
		int cycles;
		for (n = 0; n < 12; n++) begin
			r = next_random();
			addrs[n] = r[3:0];
			send_request(1'b0, addrs[n], '0);
		end
		cycles = 0;
		while (responses.size() < 12) begin
			next_if_cycle();
			cycles++;
			if (cycles > wait_limit) report_timeout("Timed out waiting for twelve responses");
		end
		repeat (40) next_if_cycle();
		check_value("back_pressure count", 12, responses.size());
		for (n = 0; n < 12; n++) begin
			check_value("back_pressure", model[addrs[n]], responses.pop_front());
		end
		cycles = 0;
		while (busy) begin
			next_if_cycle();
			cycles++;
			if (cycles > wait_limit) report_timeout("busy stayed high after the reads");
		end
	endtask

	task automatic arm_one_shot(input logic [31:0] cfg);
		bus_write(reg_main_cfg, 32'h0);
		bus_write(reg_main_hi, 32'h0);
		bus_write(reg_main_lo, 32'hffff_ff00);
		bus_write(reg_cmp0_hi, 32'h1);
		bus_write(reg_cmp0_lo, 32'h40);
		bus_write(reg_cmp0_cfg, cfg);
		bus_write(reg_main_cfg, cfg_word(1, 0, 0, 0));
	endtask

	task automatic test_one_shot();
		arm_one_shot(cfg_word(1, 1, 1, 0));
		wait_irq("one_shot", 0, 2000);
		expect_quiet("one_shot after pulse", 2000);
		// Same match with the interrupt masked
		arm_one_shot(cfg_word(1, 0, 1, 0));
		expect_quiet("one_shot masked", 2000);
	endtask

	task automatic test_periodic();
		int n;
		bus_write(reg_main_cfg, 32'h0);
		bus_write(reg_main_hi, 32'h0);
		bus_write(reg_main_lo, 32'h0);
		for (n = 0; n < 4; n++) begin
			bus_write(reg_cmp0_hi + 2 * n, 32'h0);
			bus_write(reg_cmp0_lo + 2 * n, period_of(n));
			bus_write(reg_cmp0_cfg + n, cfg_word(1, 1, 0, 1));
		end
		bus_write(reg_main_cfg, cfg_word(1, 0, 0, 0));
		measure_periods();
	endtask

	task automatic test_counter_stop();
		bus_write(reg_main_cfg, 32'h0);
		// The response proves the stop write was applied
		bus_read("counter_stop", reg_main_cfg);
		expect_quiet("counter_stop", 500);
	endtask

	initial begin
		if_clock = 1'b0;
		iTIMER_CLOCK = 1'b0;
		inRESET = 1'b0;
		req_valid = 1'b0;
		req_rw = 1'b0;
		req_addr = '0;
		req_data = '0;
		rng_state = 32'he56f;
		foreach (model[i]) model[i] = '0;
		repeat (10) @(posedge iTIMER_CLOCK);
		#1;
		inRESET = 1'b1;
		next_if_cycle();
		test_reset_state();
		test_register_table();
		test_back_pressure();
		test_one_shot();
		test_periodic();
		test_counter_stop();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: utim64.f
verilog/utim64_pkg.sv
verilog/utim64_async_fifo.sv
verilog/utim64_main_counter.sv
verilog/utim64_comparator.sv
verilog/utim64.sv
testbench/utim64_tb.sv

// File: verilog/utim64.sv
`timescale 1ns/1ps

module utim64 #(
	parameter int fifo_addr_width = 2
) (
	input logic if_clock,
	input logic iTIMER_CLOCK,
	input logic inRESET,
	input logic req_valid,
	input logic req_rw,
	input logic [utim64_pkg::reg_addr_width-1:0] req_addr,
	input logic [utim64_pkg::data_width-1:0] req_data,
	output logic busy,
	output logic resp_valid,
	output logic [utim64_pkg::data_width-1:0] resp_data,
	output logic [3:0] irq
);

	import utim64_pkg::*;

	localparam int table_depth = 15;

	utim64_req_t req_in;
	utim64_req_t head;
	logic req_empty;
	logic resp_full;
	logic resp_empty;
	logic pop;
	logic wr_fire;
	logic rd_fire;
	logic [data_width-1:0] rd_value;
	logic [data_width-1:0] reg_table [0:table_depth-1];
	logic running;
	logic [63:0] count;

	assign req_in.rw = req_rw;
	assign req_in.addr = req_addr;
	assign req_in.data = req_data;

	utim64_async_fifo #(
		.fifo_data_t(utim64_req_t),
		.fifo_addr_width(fifo_addr_width)
	) req_fifo (
		.inRESET(inRESET),
		.wr_clock(if_clock),
		.wr_en(req_valid),
		.wr_data(req_in),
		.wr_full(busy),
		.rd_clock(iTIMER_CLOCK),
		.rd_en(pop),
		.rd_data(head),
		.rd_empty(req_empty)
	);

	// Reads hold at the head while no response slot is free
	assign pop = !req_empty && (head.rw || !resp_full);
	assign wr_fire = pop && head.rw;
	assign rd_fire = pop && !head.rw;

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < table_depth; i++) begin
				reg_table[i] <= '0;
			end
		end else if (wr_fire && (head.addr < table_depth)) begin
			reg_table[head.addr] <= head.data;
		end
	end

	assign rd_value = (head.addr < table_depth) ? reg_table[head.addr] : '0;

	utim64_async_fifo #(
		.fifo_data_t(logic [data_width-1:0]),
		.fifo_addr_width(fifo_addr_width)
	) resp_fifo (
		.inRESET(inRESET),
		.wr_clock(iTIMER_CLOCK),
		.wr_en(rd_fire),
		.wr_data(rd_value),
		.wr_full(resp_full),
		.rd_clock(if_clock),
		.rd_en(!resp_empty),
		.rd_data(resp_data),
		.rd_empty(resp_empty)
	);

	assign resp_valid = !resp_empty;

	utim64_main_counter main_counter (
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET),
		.cfg_write(wr_fire && (head.addr == reg_main_cfg)),
		.cfg_data(head.data),
		.load_hi(wr_fire && (head.addr == reg_main_hi)),
		.load_lo(wr_fire && (head.addr == reg_main_lo)),
		.load_data(head.data),
		.running(running),
		.count(count)
	);

	for (genvar n = 0; n < 4; n++) begin : g_cmp
		// Channel addresses step from the channel 0 entries
		localparam logic [reg_addr_width-1:0] hi_addr = reg_addr_width'(reg_cmp0_hi + 2 * n);
		localparam logic [reg_addr_width-1:0] lo_addr = reg_addr_width'(reg_cmp0_lo + 2 * n);
		localparam logic [reg_addr_width-1:0] cfg_addr = reg_addr_width'(reg_cmp0_cfg + n);

		utim64_comparator comparator (
			.iTIMER_CLOCK(iTIMER_CLOCK),
			.inRESET(inRESET),
			.running(running),
			.count(count),
			.cfg_write(wr_fire && (head.addr == cfg_addr)),
			.cfg_data(head.data),
			.load_hi(wr_fire && (head.addr == hi_addr)),
			.load_lo(wr_fire && (head.addr == lo_addr)),
			.load_data(head.data),
			.irq(irq[n])
		);
	end

endmodule

// File: verilog/utim64_async_fifo.sv
`timescale 1ns/1ps

module utim64_async_fifo #(
	parameter type fifo_data_t = logic [31:0],
	parameter int fifo_addr_width = 2
) (
	input logic inRESET,
	input logic wr_clock,
	input logic wr_en,
	input fifo_data_t wr_data,
	output logic wr_full,
	input logic rd_clock,
	input logic rd_en,
	output fifo_data_t rd_data,
	output logic rd_empty
);

	localparam int depth = 1 << fifo_addr_width;

	fifo_data_t mem [0:depth-1];

	logic [fifo_addr_width:0] wr_bin;
	logic [fifo_addr_width:0] wr_gray;
	logic [fifo_addr_width:0] rd_bin;
	logic [fifo_addr_width:0] rd_gray;
	logic [fifo_addr_width:0] wr_bin_next;
	logic [fifo_addr_width:0] rd_bin_next;

	// Gray pointers seen from the other side
	logic [fifo_addr_width:0] rd_gray_wq1;
	logic [fifo_addr_width:0] rd_gray_wq2;
	logic [fifo_addr_width:0] wr_gray_rq1;
	logic [fifo_addr_width:0] wr_gray_rq2;

	logic wr_push;
	logic rd_pop;

	assign wr_push = wr_en && !wr_full;
	assign rd_pop = rd_en && !rd_empty;
	assign wr_bin_next = wr_bin + 1'b1;
	assign rd_bin_next = rd_bin + 1'b1;

	always_ff @(posedge wr_clock) begin
		if (wr_push) begin
			mem[wr_bin[fifo_addr_width-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge wr_clock or negedge inRESET) begin
		if (!inRESET) begin
			wr_bin <= '0;
			wr_gray <= '0;
			rd_gray_wq1 <= '0;
			rd_gray_wq2 <= '0;
		end else begin
			rd_gray_wq1 <= rd_gray;
			rd_gray_wq2 <= rd_gray_wq1;
			if (wr_push) begin
				wr_bin <= wr_bin_next;
				wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
			end
		end
	end

	always_ff @(posedge rd_clock or negedge inRESET) begin
		if (!inRESET) begin
			rd_bin <= '0;
			rd_gray <= '0;
			wr_gray_rq1 <= '0;
			wr_gray_rq2 <= '0;
		end else begin
			wr_gray_rq1 <= wr_gray;
			wr_gray_rq2 <= wr_gray_rq1;
			if (rd_pop) begin
				rd_bin <= rd_bin_next;
				rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
			end
		end
	end

	// Full when the top two Gray bits differ and the rest match
	assign wr_full = (wr_gray == {~rd_gray_wq2[fifo_addr_width:fifo_addr_width-1],
		rd_gray_wq2[fifo_addr_width-2:0]});
	assign rd_empty = (rd_gray == wr_gray_rq2);
	assign rd_data = mem[rd_bin[fifo_addr_width-1:0]];

	wr_not_full: assert property (@(posedge wr_clock) disable iff (!inRESET)
		wr_en |-> !wr_full);
	rd_not_empty: assert property (@(posedge rd_clock) disable iff (!inRESET)
		rd_en |-> !rd_empty);

endmodule

// File: verilog/utim64_comparator.sv
`timescale 1ns/1ps

module utim64_comparator (
	input logic iTIMER_CLOCK,
	input logic inRESET,
	input logic running,
	input logic [63:0] count,
	input logic cfg_write,
	input logic [utim64_pkg::data_width-1:0] cfg_data,
	input logic load_hi,
	input logic load_lo,
	input logic [utim64_pkg::data_width-1:0] load_data,
	output logic irq
);

	import utim64_pkg::*;

	logic enabled;
	logic irqena;
	logic mode64;
	logic periodic;
	logic [63:0] period;
	logic [63:0] target;
	logic hit;
	logic [63:0] target_next;

	assign hit = running && enabled &&
		(mode64 ? (target == count) : (target[31:0] == count[31:0]));

	// 32-bit mode keeps the upper half and wraps the low half
	assign target_next = mode64 ? (target + period) :
		{target[63:32], target[31:0] + period[31:0]};

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			enabled <= 1'b0;
			irqena <= 1'b0;
			mode64 <= 1'b0;
			periodic <= 1'b0;
		end else if (cfg_write) begin
			enabled <= cfg_data[cfg_ena_bit];
			irqena <= cfg_data[cfg_irqena_bit];
			mode64 <= cfg_data[cfg_64mode_bit];
			periodic <= cfg_data[cfg_periodic_bit];
		end else if (hit && !periodic) begin
			enabled <= 1'b0;
		end
	end

	always_ff @(posedge iTIMER_CLOCK) begin
		if (load_hi) begin
			period[63:32] <= load_data;
			target <= {load_data, period[31:0]};
		end else if (load_lo) begin
			period[31:0] <= load_data;
			target <= {period[63:32], load_data};
		end else if (hit && periodic) begin
			target <= target_next;
		end
	end

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq <= 1'b0;
		end else begin
			irq <= hit && irqena;
		end
	end

	// A one-shot channel fires once per arming
	one_shot_single_pulse: assert property (@(posedge iTIMER_CLOCK) disable iff (!inRESET)
		irq && !periodic && !$past(cfg_write) |=> !irq);

endmodule

// File: verilog/utim64_main_counter.sv
`timescale 1ns/1ps

module utim64_main_counter (
	input logic iTIMER_CLOCK,
	input logic inRESET,
	input logic cfg_write,
	input logic [utim64_pkg::data_width-1:0] cfg_data,
	input logic load_hi,
	input logic load_lo,
	input logic [utim64_pkg::data_width-1:0] load_data,
	output logic running,
	output logic [63:0] count
);

	import utim64_pkg::*;

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			running <= 1'b0;
		end else if (cfg_write) begin
			running <= cfg_data[cfg_ena_bit];
		end
	end

	// A half load wins over counting for that cycle
	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= 64'd0;
		end else if (load_hi) begin
			count[63:32] <= load_data;
		end else if (load_lo) begin
			count[31:0] <= load_data;
		end else if (running) begin
			count <= count + 64'd1;
		end
	end

endmodule

// File: verilog/utim64_pkg.sv
package utim64_pkg;

	parameter int data_width = 32;
	parameter int reg_addr_width = 4;

	// Register address map
	typedef enum logic [reg_addr_width-1:0] {
		reg_main_cfg = 4'd0,
		reg_main_hi = 4'd1,
		reg_main_lo = 4'd2,
		reg_cmp0_hi = 4'd3,
		reg_cmp0_lo = 4'd4,
		reg_cmp1_hi = 4'd5,
		reg_cmp1_lo = 4'd6,
		reg_cmp2_hi = 4'd7,
		reg_cmp2_lo = 4'd8,
		reg_cmp3_hi = 4'd9,
		reg_cmp3_lo = 4'd10,
		reg_cmp0_cfg = 4'd11,
		reg_cmp1_cfg = 4'd12,
		reg_cmp2_cfg = 4'd13,
		reg_cmp3_cfg = 4'd14
	} utim64_reg_e;

	// Configuration register bits
	parameter int cfg_ena_bit = 0;
	parameter int cfg_irqena_bit = 1;
	parameter int cfg_64mode_bit = 2;
	parameter int cfg_periodic_bit = 3;

	typedef struct packed {
		logic rw;
		logic [reg_addr_width-1:0] addr;
		logic [data_width-1:0] data;
	} utim64_req_t;

endpackage
